// File: regXfer.f
hw/regXferPkg.sv
hw/regSel.sv
hw/registerBank.sv
hw/microSequencer.sv
hw/regXferCore.sv
tb/regXfer_assertions.sv
tb/regXferTb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module regXferTb \
	-f regXfer.f -Mdir obj_dir

out=$(./obj_dir/VregXferTb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test OK"; then
	exit 0
else
	exit 1
fi

// File: tb/regXferTb.sv
`default_nettype none

module regXferTb import regXferPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numGpr = 6;
	localparam int resetCycles = 10;
	localparam int numMovTests = 10;
	localparam int numAddTests = 12;
	localparam int numStallTests = 4;
	localparam int numSlotTests = 2;
	// Each test pairs its instruction with an OUT; slot tests issue five.
	localparam int numInstr = 2 * numGpr + 2 * numMovTests + 2 * numAddTests
		+ 2 * numStallTests + 5 * numSlotTests;
	// Output ack hold-off while stalling.
	localparam int stallCycles = 8;

	logic clk;
	logic rstN;
	logic instrReq;
	instrT instr;
	logic instrAck;
	busWord inData;
	logic outReq;
	busWord outData;
	logic outAck;

	integer seed = 32'hdd91b941;

	// Model of the eight slots.
	// Slot 6 holds the last sum, slot 7 the value on inData.
	busWord model [8];
	busWord inValue;
	busWord expQ [$];
	int outIssued = 0;
	int outDone = 0;
	logic stallOut;

	regXferCore #(.numGpr(numGpr)) DUT (
		.clk(clk),
		.rstN(rstN),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.inData(inData),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic endWithFailure(input string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	function automatic busWord randomByte();
		return busWord'($unsigned($random(seed)));
	endfunction

	// Random general register.
	function automatic slotIdx pickReg();
		return slotIdx'($unsigned($random(seed)) % numGpr);
	endfunction

	// Full four-phase transfer of one instruction.
	// inData changes only here, while the core is idle.
	task automatic issue(input instrT ins);
		@(posedge clk);
		instr <= ins;
		inData <= inValue;
		instrReq <= 1'b1;
		do @(negedge clk); while (!instrAck);
		@(posedge clk);
		instrReq <= 1'b0;
		do @(negedge clk); while (instrAck);
	endtask

	task automatic setInput(input busWord value);
		inValue = value;
		model[slotIo] = value;
	endtask

	task automatic loadInput(input slotIdx dst, input busWord value);
		instrT ins;
		ins = '{opcode: OPC_IN, op0: dst, op1: 3'd0, op2: 3'd0};
		setInput(value);
		model[dst] = value;
		issue(ins);
	endtask

	task automatic sendOut(input slotIdx src);
		instrT ins;
		ins = '{opcode: OPC_OUT, op0: 3'd0, op1: src, op2: 3'd0};
		expQ.push_back(model[src]);
		outIssued++;
		issue(ins);
		// Back-pressure holds instrAck until the port is done.
		if (outDone != outIssued) begin
			endWithFailure("instrAck fell before the output handshake completed");
		end
	endtask

	task automatic copyReg(input slotIdx dst, input slotIdx src);
		instrT ins;
		ins = '{opcode: OPC_MOV, op0: dst, op1: src, op2: 3'd0};
		model[dst] = model[src];
		issue(ins);
	endtask

	// Sum wraps to 8 bits; the adder slot then reads the same sum.
	task automatic addRegs(input slotIdx dst, input slotIdx a, input slotIdx b);
		instrT ins;
		busWord sum;
		ins = '{opcode: OPC_ADD, op0: dst, op1: a, op2: b};
		sum = model[a] + model[b];
		model[dst] = sum;
		model[slotAdder] = sum;
		issue(ins);
	endtask

	// Output port responder.
	initial begin : outResponder
		busWord expected;
		int unsigned delay;
		outAck <= 1'b0;
		forever begin
			do @(negedge clk); while (!outReq);
			if (expQ.size() == 0) begin
				endWithFailure("outReq rose with no OUT pending");
			end
			expected = expQ.pop_front();
			if (outData !== expected) begin
				endWithFailure($sformatf("MISMATCH at %0d ns: outData %02h, expected %02h",
					$time, outData, expected));
			end
			delay = stallOut ? stallCycles : $unsigned($random(seed)) % 6;
			repeat (delay) @(posedge clk);
			@(posedge clk);
			outAck <= 1'b1;
			do @(negedge clk); while (outReq);
			@(posedge clk);
			outAck <= 1'b0;
			outDone++;
		end
	end

	// A failed bound assertion ends the run at once.
	initial begin : assertionMonitor
		forever begin
			@(negedge clk);
			if (DUT.uAssertions.failCount != 0) begin
				endWithFailure("A bound assertion on the core failed");
			end
		end
	end

	initial begin : watchdog
		repeat (resetCycles + 60 * numInstr) @(posedge clk);
		endWithFailure("Timeout: the run took longer than its cycle budget");
	end

	initial begin : stimulus
		slotIdx dst;
		slotIdx a;
		slotIdx b;
		rstN <= 1'b0;
		instrReq <= 1'b0;
		instr <= '0;
		inData <= '0;
		stallOut = 1'b0;
		inValue = '0;
		for (int i = 0; i < 8; i++) begin
			model[i] = '0;
		end
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		// Fill each register from the port, then read all back.
		for (int r = 0; r < numGpr; r++) begin
			loadInput(slotIdx'(r), randomByte());
		end
		for (int r = 0; r < numGpr; r++) begin
			sendOut(slotIdx'(r));
		end
		// Moves with every fourth one onto itself.
		for (int i = 0; i < numMovTests; i++) begin
			dst = pickReg();
			a = (i % 4 == 0) ? dst : pickReg();
			copyReg(dst, a);
			sendOut(dst);
		end
		// Sums with the destination also used as a source.
		for (int i = 0; i < numAddTests; i++) begin
			dst = pickReg();
			a = (i % 3 == 1) ? dst : pickReg();
			b = (i % 3 == 2) ? dst : pickReg();
			addRegs(dst, a, b);
			sendOut(dst);
		end
		// Slow output acks.
		stallOut = 1'b1;
		for (int i = 0; i < numStallTests; i++) begin
			sendOut(pickReg());
			dst = pickReg();
			a = pickReg();
			copyReg(dst, a);
		end
		stallOut = 1'b0;
		// Adder and I/O slots as MOV sources.
		for (int i = 0; i < numSlotTests; i++) begin
			dst = pickReg();
			a = pickReg();
			b = pickReg();
			addRegs(dst, a, b);
			dst = pickReg();
			copyReg(dst, slotAdder);
			sendOut(dst);
			setInput(randomByte());
			dst = pickReg();
			copyReg(dst, slotIo);
			sendOut(dst);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/regXfer_assertions.sv
`default_nettype none

module regXfer_assertions import regXferPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrReq,
	input logic instrAck,
	input logic outReq,
	input busWord outData,
	input logic outAck,
	input logic [7:0] regNotOEs,
	input logic [7:0] regNotLoads
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions so far.
	int unsigned failCount = 0;

	// At most one slot drives the bus.
	oeOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(~regNotOEs))
		else begin
			failCount++;
			$error("regNotOEs has more than one low bit: %b", regNotOEs);
		end

	// At most one slot loads from the bus.
	loadOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(~regNotLoads))
		else begin
			failCount++;
			$error("regNotLoads has more than one low bit: %b", regNotLoads);
		end

	// Both handshake outputs come out of reset low.
	resetIdle: assert property (@(posedge clk) !rstN |=> !instrAck && !outReq)
		else begin
			failCount++;
			$error("instrAck or outReq high one cycle after reset");
		end

	// instrAck follows instrReq.
	ackRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(instrAck) |-> $past(instrReq))
		else begin
			failCount++;
			$error("instrAck rose while instrReq was low");
		end

	ackFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(instrAck) |-> !$past(instrReq))
		else begin
			failCount++;
			$error("instrAck fell while instrReq was high");
		end

	// The sequencer is the requester on the output port.
	outReqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> !$past(outAck))
		else begin
			failCount++;
			$error("outReq rose before outAck was low");
		end

	outReqFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(outReq) |-> $past(outAck))
		else begin
			failCount++;
			$error("outReq fell without outAck");
		end

	// Data held for the whole request.
	outDataHeld: assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outData))
		else begin
			failCount++;
			$error("outData changed while outReq was high");
		end

endmodule

bind regXferCore regXfer_assertions uAssertions (
	.clk(clk),
	.rstN(rstN),
	.instrReq(instrReq),
	.instrAck(instrAck),
	.outReq(outReq),
	.outData(outData),
	.outAck(outAck),
	.regNotOEs(regNotOEs),
	.regNotLoads(regNotLoads)
);

`default_nettype wire

// File: hw/regXferCore.sv
`default_nettype none

module regXferCore import regXferPkg::*; #(
	parameter int numGpr = 6
) (
	input logic clk,
	input logic rstN,
	input logic instrReq,
	input instrT instr,
	output logic instrAck,
	input busWord inData,
	output logic outReq,
	output busWord outData,
	input logic outAck
);

	// Sequencer to selector.
	microOpT uop;
	instrT curInstr;

	// Selector to bank, active low one-hot.
	logic [7:0] regNotOEs;
	logic [7:0] regNotLoads;

	// Bank back to sequencer.
	busWord outWord;
	logic outStrobe;

	microSequencer uSeq (
		.clk(clk),
		.rstN(rstN),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.uop(uop),
		.curInstr(curInstr),
		.outStrobe(outStrobe),
		.outWord(outWord),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	regSel uRegSel (
		.uop(uop),
		.curInstr(curInstr),
		.regNotOEs(regNotOEs),
		.regNotLoads(regNotLoads)
	);

	registerBank #(
		.numGpr(numGpr)
	) uBank (
		.clk(clk),
		.rstN(rstN),
		.regNotOEs(regNotOEs),
		.regNotLoads(regNotLoads),
		.inData(inData),
		.outWord(outWord),
		.outStrobe(outStrobe)
	);

endmodule

`default_nettype wire

// File: hw/microSequencer.sv
`default_nettype none

module microSequencer import regXferPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrReq,
	input instrT instr,
	output logic instrAck,
	output microOpT uop,
	output instrT curInstr,
	input logic outStrobe,
	input busWord outWord,
	output logic outReq,
	output busWord outData,
	input logic outAck
);

	seqStateT state;

	// Current micro-op step within the instruction.
	logic [1:0] step;

	// Builds one active microcode word.
	function automatic microOpT uopWord(
		input oeSrcT oeSrc,
		input slotIdx useqOe,
		input ldSrcT ldSrc,
		input slotIdx useqLoad
	);
		microOpT u;
		u.oe = 1'b1;
		u.load = 1'b1;
		u.oeSrc = oeSrc;
		u.ldSrc = ldSrc;
		u.useqOe = useqOe;
		u.useqLoad = useqLoad;
		return u;
	endfunction

	// Microcode table, indexed by opcode and step.
	function automatic microOpT ucode(input opcodeT opc, input logic [1:0] s);
		microOpT u;
		u = '0;
		case (opc)
			OPC_MOV: u = uopWord(OE_OP1, 3'd0, LD_OP0, 3'd0);
			OPC_IN: u = uopWord(OE_MICRO, slotIo, LD_OP0, 3'd0);
			OPC_OUT: u = uopWord(OE_OP1, 3'd0, LD_MICRO, slotIo);
			OPC_ADD: begin
				// Stage op1 then op2, then write back the sum.
				case (s)
					2'd0: u = uopWord(OE_OP1, 3'd0, LD_MICRO, slotAdder);
					2'd1: u = uopWord(OE_OP2, 3'd0, LD_MICRO, slotAdder);
					default: u = uopWord(OE_MICRO, slotAdder, LD_OP0, 3'd0);
				endcase
			end
			default: u = '0;
		endcase
		return u;
	endfunction

	// Index of the final step.
	function automatic logic [1:0] lastStep(input opcodeT opc);
		return (opc == OPC_ADD) ? 2'd2 : 2'd0;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
			step <= '0;
			instrAck <= 1'b0;
			outReq <= 1'b0;
			uop <= '0;
		end else begin
			// Bus idle unless a step is issued below.
			uop <= '0;
			case (state)
				IDLE: begin
					if (instrReq) begin
						step <= '0;
						state <= EXEC;
					end
				end
				EXEC: begin
					// Ack goes up one edge after acceptance.
					instrAck <= 1'b1;
					uop <= ucode(curInstr.opcode, step);
					step <= step + 2'd1;
					if (step == lastStep(curInstr.opcode)) begin
						state <= (curInstr.opcode == OPC_OUT) ? OUT_ACK_HIGH : WAIT_REQ_LOW;
					end
				end
				OUT_ACK_HIGH: begin
					// The bank strobes one edge after the I/O load.
					if (outStrobe) begin
						outReq <= 1'b1;
					end else if (outReq && outAck) begin
						outReq <= 1'b0;
						state <= OUT_ACK_LOW;
					end
				end
				OUT_ACK_LOW: begin
					// Back-pressure ends here.
					if (!outAck) begin
						state <= WAIT_REQ_LOW;
					end
				end
				WAIT_REQ_LOW: begin
					if (!instrReq) begin
						instrAck <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Instruction latch.
	always_ff @(posedge clk) begin
		if (state == IDLE && instrReq) begin
			curInstr <= instr;
		end
	end

	// Output word, held while outReq is high.
	always_ff @(posedge clk) begin
		if (state == OUT_ACK_HIGH && outStrobe) begin
			outData <= outWord;
		end
	end

endmodule

`default_nettype wire

// File: hw/registerBank.sv
`default_nettype none

// numGpr must not exceed slotAdder.
module registerBank import regXferPkg::*; #(
	parameter int numGpr = 6
) (
	input logic clk,
	input logic rstN,
	input logic [7:0] regNotOEs,
	input logic [7:0] regNotLoads,
	input busWord inData,
	output busWord outWord,
	output logic outStrobe
);

	// General registers, slots 0 to numGpr-1.
	busWord gpr [numGpr];

	// Adder operand latches.
	busWord addA;
	busWord addB;
	busWord adderSum;

	// Resolved bus value.
	busWord bus;

	// Wraps modulo 256.
	assign adderSum = addA + addB;

	// Wired OR of every enabled driver.
	// Unused slots between numGpr and slotAdder add nothing.
	always_comb begin
		bus = '0;
		for (int i = 0; i < numGpr; i++) begin
			if (!regNotOEs[i]) begin
				bus = bus | gpr[i];
			end
		end
		if (!regNotOEs[slotAdder]) begin
			bus = bus | adderSum;
		end
		if (!regNotOEs[slotIo]) begin
			bus = bus | inData;
		end
	end

	// General register writes.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numGpr; i++) begin
				gpr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < numGpr; i++) begin
				if (!regNotLoads[i]) begin
					gpr[i] <= bus;
				end
			end
		end
	end

	// Adder slot.
	// A load shifts A into B, so two loads stage both operands.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			addA <= '0;
			addB <= '0;
		end else if (!regNotLoads[slotAdder]) begin
			addB <= addA;
			addA <= bus;
		end
	end

	// I/O slot load.
	// Captures the bus for the output port and flags it for one cycle.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			outStrobe <= 1'b0;
		end else begin
			outStrobe <= !regNotLoads[slotIo];
		end
	end

	always_ff @(posedge clk) begin
		if (!regNotLoads[slotIo]) begin
			outWord <= bus;
		end
	end

endmodule

`default_nettype wire

// File: hw/regSel.sv
`default_nettype none

module regSel import regXferPkg::*; (
	input microOpT uop,
	input instrT curInstr,
	output logic [7:0] regNotOEs,
	output logic [7:0] regNotLoads
);

	// Slot numbers after the source muxes.
	slotIdx oeSlot;
	slotIdx loadSlot;

	// Drive source mux, four inputs.
	always_comb begin
		case (uop.oeSrc)
			OE_MICRO: oeSlot = uop.useqOe;
			OE_OP0: oeSlot = curInstr.op0;
			OE_OP1: oeSlot = curInstr.op1;
			OE_OP2: oeSlot = curInstr.op2;
			default: oeSlot = uop.useqOe;
		endcase
	end

	// Load source mux, two inputs.
	always_comb begin
		case (uop.ldSrc)
			LD_MICRO: loadSlot = uop.useqLoad;
			LD_OP0: loadSlot = curInstr.op0;
			default: loadSlot = uop.useqLoad;
		endcase
	end

	// Drive decoder.
	// All outputs stay high while oe is low, like a disabled 3-to-8 decoder.
	always_comb begin
		regNotOEs = '1;
		if (uop.oe) begin
			regNotOEs[oeSlot] = 1'b0;
		end
	end

	// Load decoder, same behaviour gated by load.
	always_comb begin
		regNotLoads = '1;
		if (uop.load) begin
			regNotLoads[loadSlot] = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/regXferPkg.sv
`default_nettype none

package regXferPkg;

	// One word on the shared data bus.
	typedef logic [7:0] busWord;

	// Number of one of the eight bus slots.
	typedef logic [2:0] slotIdx;

	typedef enum logic [1:0] {
		OPC_MOV,
		OPC_ADD,
		OPC_IN,
		OPC_OUT
	} opcodeT;

	// Opcode plus destination and two source slot fields.
	typedef struct packed {
		opcodeT opcode;
		slotIdx op0;
		slotIdx op1;
		slotIdx op2;
	} instrT;

	// Where the drive slot number comes from.
	typedef enum logic [1:0] {
		OE_MICRO,
		OE_OP0,
		OE_OP1,
		OE_OP2
	} oeSrcT;

	// Where the load slot number comes from.
	typedef enum logic {
		LD_MICRO,
		LD_OP0
	} ldSrcT;

	// One microcode word.
	typedef struct packed {
		logic oe;
		logic load;
		oeSrcT oeSrc;
		ldSrcT ldSrc;
		slotIdx useqOe;
		slotIdx useqLoad;
	} microOpT;

	// Fixed slots above the general registers.
	localparam slotIdx slotAdder = 3'd6;
	localparam slotIdx slotIo = 3'd7;

	typedef enum logic [2:0] {
		IDLE,
		EXEC,
		WAIT_REQ_LOW,
		OUT_ACK_HIGH,
		OUT_ACK_LOW
	} seqStateT;

endpackage

`default_nettype wire
